//--- design/opc8_alu.sv
`timescale 1ns/1ns
`include "opc8_defines.svh"

module opc8_alu (
  input  opc8_pkg::opcode_t opcode,
  input  opc8_pkg::word_t   operand,
  input  opc8_pkg::word_t   reg_value,
  input  logic [7:0]        psr,
  input  logic              dst_is_pc,
  output opc8_pkg::word_t   result,
  output logic [7:0]        psr_next
);
  import opc8_pkg::*;

  localparam int W = `OPC8_WORD_W;

  logic carry;
  logic sub_cin;

  // Operand arrives already inverted for SUB and CMP
  assign sub_cin = (opcode != OP_ADD);

  always_comb begin
    carry  = psr[FLAG_C];   // Carry holds unless the opcode defines it
    result = operand;       // MOV, LD, JSR and friends pass the operand
    case (opcode)
      OP_AND: result = reg_value & operand;
      OP_OR:  result = reg_value | operand;
      OP_XOR: result = reg_value ^ operand;
      OP_NOT: result = ~operand;
      OP_ADD, OP_SUB, OP_CMP: begin
        {carry, result} = {1'b0, reg_value} + {1'b0, operand}
                          + (W+1)'(sub_cin);
      end
      OP_ROL: {carry, result} = {operand, psr[FLAG_C]};
      OP_ROR: {result, carry} = {psr[FLAG_C], operand};
      OP_ASR: {result, carry} = {operand[W-1], operand};
      OP_LSR: {result, carry} = {1'b0, operand};
      OP_BROL: begin
        result = {operand[W-9:0], operand[W-1:W-8]};
        carry  = |operand[W-1:W-8];  // Set if a nonzero byte wrapped
      end
      OP_BROR: begin
        result = {operand[7:0], operand[W-1:8]};
        carry  = |operand[7:0];
      end
      OP_GPSR: result = {{(W-8){1'b0}}, psr};
      default: result = operand;
    endcase
  end

  always_comb begin
    psr_next = psr;
    if (opcode == OP_PPSR) begin
      psr_next = operand[7:0];
    end else if (!dst_is_pc) begin
      // Jumps keep the flags intact
      psr_next[FLAG_S] = result[W-1];
      psr_next[FLAG_C] = carry;
      psr_next[FLAG_Z] = ~|result;
    end
  end

endmodule

//--- design/opc8_cpu.sv
`timescale 1ns/1ns

module opc8_cpu (
  input  logic            clk,
  input  logic            reset_s1_b,
  input  opc8_pkg::word_t din,
  output opc8_pkg::word_t dout,
  output opc8_pkg::word_t address,
  output logic            rnw,
  output logic            vpa,
  output logic            vda
);
  import opc8_pkg::*;

  seq_state_t state_q;
  seq_state_t state_d;

  word_t      pc_q;
  logic [7:0] psr_q;
  word_t      rf_q [15];      // r0..r14, PC lives in pc_q
  word_t      rf_pipe_q;      // Destination register read
  word_t      or_q;           // Operand, then effective address
  opcode_t    ir_q;
  logic [3:0] dst_q;
  logic [3:0] src_q;
  logic [2:0] pred_q;
  logic       rnw_q;
  logic       vpa_q;
  logic       vda_q;

  logic       din_long;
  opcode_t    din_opcode;
  word_t      din_imm;
  word_t      src_val;
  word_t      ea;
  logic       sub_op;
  logic       pred_ok;
  word_t      alu_result;
  logic [7:0] psr_next;

  // Instruction word: pred[23:21] len/op[20:16] dst[15:12] src[11:8] imm[7:0]
  assign din_long   = (din[20:19] == 2'b11);
  assign din_opcode = opcode_t'({din_long ? 2'b10 : din[20:19], din[18:16]});

  // Short immediate only sign extends when a source register is named
  assign din_imm = {{($bits(word_t)-8){din[7] & (|din[11:8])}}, din[7:0]};

  always_comb begin
    src_val = '0;                     // r0 reads as zero
    if (src_q == 4'hF) begin
      src_val = pc_q;
    end else if (src_q != 4'h0) begin
      src_val = rf_q[src_q];
    end
  end

  assign ea     = src_val + or_q;
  assign sub_op = (ir_q == OP_SUB) || (ir_q == OP_CMP);

  // pred[0] inverts; pred[2:1] pick always, Z, C or S
  assign pred_ok = pred_q[0] ^ (pred_q[1] ? (pred_q[2] ? psr_q[FLAG_S] : psr_q[FLAG_Z])
                                          : (pred_q[2] ? psr_q[FLAG_C] : 1'b1));

  always_comb begin
    case (state_q)
      FET:  state_d = din_long ? FET1 : EAD;
      FET1: state_d = EAD;
      EAD: begin
        if (!pred_ok) begin
          state_d = FET;              // Skipped, PC already past it
        end else if (ir_q == OP_LD) begin
          state_d = RDM;
        end else if (ir_q == OP_STO) begin
          state_d = WRM;
        end else begin
          state_d = EXEC;
        end
      end
      RDM:  state_d = EXEC;
      EXEC: begin
        // Flow change discards the overlapped fetch
        if (dst_q == 4'hF || ir_q == OP_JSR) begin
          state_d = FET;
        end else begin
          state_d = din_long ? FET1 : EAD;
        end
      end
      default: state_d = FET;         // WRM
    endcase
  end

  opc8_alu alu0 (
    .opcode    (ir_q),
    .operand   (or_q),
    .reg_value (rf_pipe_q),
    .psr       (psr_q),
    .dst_is_pc (dst_q == 4'hF),
    .result    (alu_result),
    .psr_next  (psr_next)
  );

  always_ff @(posedge clk) begin
    if (!reset_s1_b) begin
      state_q <= FET;
      pc_q    <= '0;
      psr_q   <= '0;
      rnw_q   <= 1'b1;
      vpa_q   <= 1'b1;
      vda_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      rnw_q   <= (state_d != WRM);
      vpa_q   <= (state_d inside {FET, FET1, EXEC});
      vda_q   <= (state_d inside {RDM, WRM});
      case (state_q)
        FET, FET1: pc_q <= pc_q + 1'b1;
        EXEC: begin
          psr_q <= psr_next;
          if (dst_q == 4'hF) begin
            pc_q <= alu_result;
          end else if (ir_q == OP_JSR) begin
            pc_q <= or_q;
          end else begin
            pc_q <= pc_q + 1'b1;    // Next word was fetched in EXEC
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    rf_pipe_q <= (dst_q == 4'hF) ? pc_q : (dst_q == 4'h0) ? '0 : rf_q[dst_q];
    case (state_q)
      FET, EXEC: or_q <= din_imm;
      EAD:       or_q <= sub_op ? ~ea : ea;
      default:   or_q <= din;       // Long operand or load data
    endcase
    if (state_q == FET || state_q == EXEC) begin
      ir_q   <= din_opcode;
      dst_q  <= din[15:12];
      src_q  <= din[11:8];
      pred_q <= din[23:21];
    end else if (state_q == EAD && ir_q == OP_CMP) begin
      dst_q  <= 4'h0;               // CMP keeps flags only
    end
    if (state_q == EXEC && dst_q != 4'hF) begin
      rf_q[dst_q] <= (ir_q == OP_JSR) ? pc_q : alu_result;   // JSR saves return address
    end
  end

  assign address = vpa_q ? pc_q : or_q;
  assign dout    = rf_pipe_q;
  assign rnw     = rnw_q;
  assign vpa     = vpa_q;
  assign vda     = vda_q;

endmodule

//--- design/opc8_defines.svh
`ifndef OPC8_DEFINES_SVH
`define OPC8_DEFINES_SVH

// Data bus, address bus and register width
`define OPC8_WORD_W 24

// Words in the unified program and data memory
`define OPC8_MEM_DEPTH 4096

// Store here emits one result word
`define OPC8_OUT_ADDR 24'hFFFF00

// Store here ends the program
`define OPC8_DONE_ADDR 24'hFFFF01

`endif

//--- design/opc8_mem.sv
`timescale 1ns/1ns
`include "opc8_defines.svh"

module opc8_mem (
  input  logic            clk,
  input  opc8_pkg::word_t address,
  input  opc8_pkg::word_t dout,
  input  logic            rnw,
  input  logic            vda,
  input  logic            load_en,
  input  opc8_pkg::word_t load_addr,
  input  opc8_pkg::word_t load_data,
  output opc8_pkg::word_t din
);
  import opc8_pkg::*;

  localparam int ADDR_BITS = $clog2(`OPC8_MEM_DEPTH);

  word_t mem_q [`OPC8_MEM_DEPTH];

  logic [ADDR_BITS-1:0] core_idx;
  logic [ADDR_BITS-1:0] load_idx;
  logic                 core_we;

  assign core_idx = address[ADDR_BITS-1:0];   // Upper address bits wrap
  assign load_idx = load_addr[ADDR_BITS-1:0];

  // Port range stores belong to the output port only
  assign core_we = vda && !rnw && (address < `OPC8_OUT_ADDR);

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem_q[load_idx] <= load_data;  // Host image load wins
    end else if (core_we) begin
      mem_q[core_idx] <= dout;
    end
  end

  // Fetches and loads complete in the same cycle
  assign din = mem_q[core_idx];

endmodule

//--- design/opc8_out_port.sv
`timescale 1ns/1ns
`include "opc8_defines.svh"

module opc8_out_port (
  input  logic            clk,
  input  logic            reset_s1_b,
  input  opc8_pkg::word_t address,
  input  opc8_pkg::word_t dout,
  input  logic            rnw,
  input  logic            vda,
  output logic            out_valid,
  output opc8_pkg::word_t out_data,
  output logic            done
);

  logic store;
  logic out_hit;
  logic done_hit;

  assign store    = vda && !rnw;    // Only WRM drives rnw low
  assign out_hit  = store && (address == `OPC8_OUT_ADDR);
  assign done_hit = store && (address == `OPC8_DONE_ADDR);

  always_ff @(posedge clk) begin
    if (!reset_s1_b) begin
      out_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      out_valid <= out_hit;         // One pulse per store
      if (done_hit) begin
        done <= 1'b1;               // Sticky until reset
      end
    end
  end

  // Result word lines up with the strobe
  always_ff @(posedge clk) begin
    if (out_hit) begin
      out_data <= dout;
    end
  end

endmodule

//--- design/opc8_pkg.sv
`include "opc8_defines.svh"

package opc8_pkg;

  typedef logic [`OPC8_WORD_W-1:0] word_t;

  // Long forms 0x18..0x1F alias onto 0x10..0x17
  typedef enum logic [4:0] {
    OP_HALT  = 5'h00,
    OP_NOT   = 5'h01,
    OP_OR    = 5'h02,
    OP_XOR   = 5'h03,
    OP_BPERM = 5'h04,
    OP_ROR   = 5'h05,
    OP_LSR   = 5'h06,
    OP_ASR   = 5'h07,
    OP_ROL   = 5'h08,
    OP_PPSR  = 5'h0A,
    OP_GPSR  = 5'h0B,
    OP_BROR  = 5'h0C,
    OP_BROL  = 5'h0D,
    OP_MOV   = 5'h10,
    OP_JSR   = 5'h11,
    OP_CMP   = 5'h12,
    OP_SUB   = 5'h13,
    OP_ADD   = 5'h14,
    OP_AND   = 5'h15,
    OP_STO   = 5'h16,
    OP_LD    = 5'h17
  } opcode_t;

  typedef enum logic [2:0] {
    FET  = 3'h0,  // Instruction word fetch
    FET1 = 3'h1,  // Long operand fetch
    EAD  = 3'h2,  // Effective address and predicate
    RDM  = 3'h3,
    EXEC = 3'h4,  // Writeback, overlapped with next fetch
    WRM  = 3'h5
  } seq_state_t;

  // Flag bit positions in the 8-bit status register
  typedef enum int {
    FLAG_Z = 0,
    FLAG_C = 1,
    FLAG_S = 2
  } flag_idx_e;

endpackage

//--- design/opc8_system.sv
`timescale 1ns/1ns

module opc8_system (
  input  logic            clk,
  input  logic            reset_s1_b,
  input  logic            load_en,
  input  opc8_pkg::word_t load_addr,
  input  opc8_pkg::word_t load_data,
  output logic            out_valid,
  output opc8_pkg::word_t out_data,
  output logic            done
);
  import opc8_pkg::*;

  word_t address;
  word_t cpu_dout;
  word_t mem_din;
  logic  rnw;
  logic  vda;

  opc8_mem mem0 (
    .clk       (clk),
    .address   (address),
    .dout      (cpu_dout),
    .rnw       (rnw),
    .vda       (vda),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .din       (mem_din)
  );

  opc8_cpu cpu0 (
    .clk        (clk),
    .reset_s1_b (reset_s1_b),
    .din        (mem_din),
    .dout       (cpu_dout),
    .address    (address),
    .rnw        (rnw),
    .vpa        (),                 // Unified memory needs no fetch marker
    .vda        (vda)
  );

  opc8_out_port out_port0 (
    .clk        (clk),
    .reset_s1_b (reset_s1_b),
    .address    (address),
    .dout       (cpu_dout),
    .rnw        (rnw),
    .vda        (vda),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .done       (done)
  );

endmodule

//--- list.f
+incdir+design
design/opc8_pkg.sv
design/opc8_mem.sv
design/opc8_alu.sv
design/opc8_cpu.sv
design/opc8_out_port.sv
design/opc8_system.sv
sim/opc8_model.sv
sim/opc8_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the opc8 testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module opc8_tb -f list.f -o sim_opc8
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi
output=$(./obj_dir/sim_opc8)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

//--- sim/opc8_model.sv
`include "opc8_defines.svh"

package opc8_model;
  import opc8_pkg::*;

  localparam int NUM_INSTR = 40;
  localparam int DATA_BASE = 'h800;
  localparam opcode_t REG_OPS [7] = '{OP_MOV, OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_OR, OP_XOR};
  localparam opcode_t SHORT_OPS [8] = '{OP_NOT, OP_ROR, OP_LSR, OP_ASR, OP_ROL, OP_BROL,
                                        OP_BROR, OP_GPSR};

  word_t img [`OPC8_MEM_DEPTH];
  int    load_list [$];       // Addresses the host loads
  word_t exp_q [$];           // Expected out_data words in order

  function automatic void put_word(input int addr, input word_t w);
    img[addr] = w;
    load_list.push_back(addr);
  endfunction

  function automatic word_t encode(input logic [2:0] pred, input opcode_t op,
                                   input logic [3:0] dst, input logic [3:0] src,
                                   input logic [7:0] imm, input bit lng);
    logic [4:0] code;
    code = op;
    if (lng) begin
      code = {2'b11, code[2:0]};  // Long form of a 0x1x opcode
    end
    return {pred, code, dst, src, imm};
  endfunction

  // Emits one instruction and its optional long operand, returns the next address
  function automatic int emit(input int a, input word_t w, input bit lng, input word_t opnd);
    put_word(a, w);
    if (lng) begin
      put_word(a + 1, opnd);
      return a + 2;
    end
    return a + 1;
  endfunction

  function automatic void gen_program();
    int a;
    int k;
    bit lng;
    logic [2:0] pred;
    logic [3:0] dst;
    logic [3:0] src;
    opcode_t op;
    load_list.delete();
    a = 0;
    for (int r = 1; r < 15; r++) begin
      a = emit(a, encode(3'd0, OP_MOV, 4'(r), 4'd0, 8'd0, 1'b1), 1'b1, word_t'($urandom));
    end
    for (int i = 0; i < 16; i++) begin
      put_word(DATA_BASE + i, word_t'($urandom));
    end
    for (int n = 0; n < NUM_INSTR; n++) begin
      pred = ($urandom_range(1, 0) == 1) ? 3'd0 : 3'($urandom_range(7, 0));
      dst  = 4'($urandom_range(14, 1));
      src  = 4'($urandom_range(14, 0));
      case ($urandom_range(8, 0))
        0, 1, 2, 3: begin
          op  = REG_OPS[$urandom_range(6, 0)];
          lng = ($urandom_range(1, 0) == 1);
          a = emit(a, encode(pred, op, dst, src, 8'($urandom), lng), lng, word_t'($urandom));
        end
        4, 5: begin
          op = SHORT_OPS[$urandom_range(7, 0)];
          a = emit(a, encode(pred, op, dst, src, 8'($urandom), 1'b0), 1'b0, '0);
        end
        6: a = emit(a, encode(pred, OP_LD, dst, 4'd0, 8'd0, 1'b1), 1'b1,
                    word_t'(DATA_BASE + $urandom_range(15, 0)));
        7: a = emit(a, encode(pred, OP_STO, dst, 4'd0, 8'd0, 1'b1), 1'b1,
                    word_t'(DATA_BASE + $urandom_range(15, 0)));
        default: begin
          k = $urandom_range(2, 0);   // Filler words jumped over
          a = emit(a, encode(pred, OP_JSR, dst, 4'd0, 8'd0, 1'b1), 1'b1, word_t'(a + 2 + k));
          repeat (k) begin
            a = emit(a, encode(3'd0, OP_MOV, 4'($urandom_range(14, 1)), 4'd0, 8'($urandom), 1'b0),
                     1'b0, '0);
          end
        end
      endcase
    end
    for (int r = 1; r < 15; r++) begin
      a = emit(a, encode(3'd0, OP_STO, 4'(r), 4'd0, 8'd0, 1'b1), 1'b1, `OPC8_OUT_ADDR);
    end
    a = emit(a, encode(3'd0, OP_STO, 4'd0, 4'd0, 8'd0, 1'b1), 1'b1, `OPC8_DONE_ADDR);
    a = emit(a, encode(3'd0, OP_MOV, 4'hF, 4'd0, 8'd0, 1'b1), 1'b1, word_t'(a));  // Park
  endfunction

  function automatic void run_model();
    word_t      mem [`OPC8_MEM_DEPTH];
    word_t      rf [16];
    logic [7:0] psr;
    word_t      pc;
    word_t      w;
    word_t      operand;
    word_t      ea;
    word_t      rd;
    word_t      res;
    logic       carry;
    logic       ok;
    logic [4:0] code;
    logic [3:0] dst;
    logic [3:0] src;
    mem = img;
    exp_q.delete();
    psr = '0;
    pc  = '0;
    foreach (rf[i]) rf[i] = '0;
    for (int step = 0; step < 4000; step++) begin
      w   = mem[pc[11:0]];
      pc  = pc + 1;
      dst = w[15:12];
      src = w[11:8];
      if (w[20:19] == 2'b11) begin
        code    = {2'b10, w[18:16]};
        operand = mem[pc[11:0]];
        pc      = pc + 1;
      end else begin
        code    = w[20:16];
        operand = (src != 0) ? {{16{w[7]}}, w[7:0]} : {16'd0, w[7:0]};
      end
      case (w[23:22])                 // Condition select, w[21] inverts
        2'b00:   ok = 1'b1;
        2'b01:   ok = psr[FLAG_Z];
        2'b10:   ok = psr[FLAG_C];
        default: ok = psr[FLAG_S];
      endcase
      if (!(ok ^ w[21])) continue;
      ea    = ((src == 0) ? '0 : rf[src]) + operand;
      rd    = (dst == 0) ? '0 : rf[dst];
      carry = psr[FLAG_C];
      res   = ea;
      if (code == OP_STO) begin
        if (ea == `OPC8_OUT_ADDR) exp_q.push_back(rd);
        else if (ea == `OPC8_DONE_ADDR) return;
        else if (ea < `OPC8_OUT_ADDR) mem[ea[11:0]] = rd;
        continue;
      end
      case (code)
        OP_LD:          res = mem[ea[11:0]];
        OP_ADD:         {carry, res} = {1'b0, rd} + {1'b0, ea};
        OP_SUB, OP_CMP: {carry, res} = {1'b0, rd} + {1'b0, ~ea} + 25'd1;
        OP_AND:         res = rd & ea;
        OP_OR:          res = rd | ea;
        OP_XOR:         res = rd ^ ea;
        OP_NOT:         res = ~ea;
        OP_ROL: begin res = {ea[22:0], psr[FLAG_C]}; carry = ea[23]; end
        OP_ROR: begin res = {psr[FLAG_C], ea[23:1]}; carry = ea[0]; end
        OP_ASR: begin res = {ea[23], ea[23:1]}; carry = ea[0]; end
        OP_LSR: begin res = {1'b0, ea[23:1]}; carry = ea[0]; end
        OP_BROL: begin res = {ea[15:0], ea[23:16]}; carry = |ea[23:16]; end
        OP_BROR: begin res = {ea[7:0], ea[23:8]}; carry = |ea[7:0]; end
        OP_GPSR:        res = {16'd0, psr};
        default:        res = ea;
      endcase
      if (dst == 4'hF) begin
        pc = res;                     // Jumps leave flags alone
        continue;
      end
      if (code == OP_JSR) begin
        rf[dst] = pc;
        pc      = ea;
      end else if (code != OP_CMP) begin
        rf[dst] = res;
      end
      psr[FLAG_S] = res[23];
      psr[FLAG_C] = carry;
      psr[FLAG_Z] = (res == 0);
    end
  endfunction

endpackage

//--- sim/opc8_tb.sv
`timescale 1ns/1ns
`include "opc8_defines.svh"

module opc8_tb;
  import opc8_pkg::*;
  import opc8_model::*;

  localparam int NUM_PROGS = 10;
  localparam int TIMEOUT   = 5000;

  logic  clk;
  logic  reset_s1_b;
  logic  load_en;
  word_t load_addr;
  word_t load_data;
  logic  out_valid;
  word_t out_data;
  logic  done;
  int    errors;
  int    timeouts;

  opc8_system dut0 (
    .clk        (clk),
    .reset_s1_b (reset_s1_b),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .done       (done)
  );

  always #2 clk = ~clk;

  // Inputs change and outputs are sampled 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_result(inout int run_cycles, output bit timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    while (!out_valid && !done) begin
      if (cycles == TIMEOUT) begin
        timed_out = 1'b1;
        return;
      end
      step();
      cycles++;
      run_cycles++;
    end
  endtask

  task automatic run_program(input int p);
    int got;
    int run_cycles;
    bit timed_out;
    gen_program();
    run_model();
    reset_s1_b = 1'b0;
    foreach (load_list[i]) begin      // Image goes in while the core is held
      load_en   = 1'b1;
      load_addr = word_t'(load_list[i]);
      load_data = img[load_list[i]];
      step();
    end
    load_en = 1'b0;
    repeat (5) step();
    reset_s1_b = 1'b1;
    step();
    check_level("out_valid", out_valid, 1'b0);
    check_level("done", done, 1'b0);
    got        = 0;
    run_cycles = 0;
    timed_out  = 1'b0;
    while (!done && !timed_out) begin
      if (run_cycles >= TIMEOUT) begin
        $display("Timeout: program %0d did not raise done within %0d cycles", p, TIMEOUT);
        timed_out = 1'b1;
        timeouts++;
      end else begin
        wait_result(run_cycles, timed_out);
        if (timed_out) begin
          $display("Timeout: program %0d gave no result and no done in %0d cycles", p, TIMEOUT);
          timeouts++;
        end else begin
          if (out_valid) begin
            if (got < exp_q.size()) check_word("out_data", out_data, exp_q[got]);
            got++;
          end
          if (!done) begin
            step();
            run_cycles++;
          end
        end
      end
    end
    if (!timed_out) begin
      check_count("result count", got, exp_q.size());
      repeat (50) begin
        step();
        if (out_valid) begin
          $display("Program %0d raised out_valid after done", p);
          errors++;
        end
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    reset_s1_b = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    errors     = 0;
    timeouts   = 0;
    void'($urandom(32'h4104978c));
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program(p);
    end
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
